// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_user_io
FILELIST  = list.f
OBJDIR    = obj_dir
SIMFLAGS  = +verilator+error+limit+100
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: include/user_io_consts.svh
`ifndef USER_IO_CONSTS_SVH
`define USER_IO_CONSTS_SVH

// first byte of every user-io answer, 8 bit core
`define UIO_CORE_TYPE 8'ha4

// ps2 queue address width, 8 entries
`define UIO_PS2_FIFO_BITS 3

// pin synchronizer depth
`define UIO_SYNC_STAGES 2

// download start addresses by file index
// boot rom, index 0x00
`define UIO_DL_BASE_BOOT 25'h0080000
// rom or com file, index 0x01 and 0x41
`define UIO_DL_BASE_ROM 25'h0000100
// c00 file, index 0x81
`define UIO_DL_BASE_C00 25'h0000000
// edd file, index 0xc1
`define UIO_DL_BASE_EDD 25'h0010000
// fdd file, everything else
`define UIO_DL_BASE_FDD 25'h0100000

`endif

// File: list.f
+incdir+include
verilog/user_io_pkg.sv
verilog/spi_byte_link.sv
verilog/uio_cmd_decoder.sv
verilog/ps2_tx_channel.sv
verilog/ioctl_download.sv
verilog/user_io_top.sv
testbench/tb_clk_gen.sv
testbench/user_io_props.sv
testbench/tb_user_io.sv

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_sys,
	output logic CONF_DATA0
);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// reset drops just after a rising edge, like the other inputs
	initial begin
		CONF_DATA0 = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		CONF_DATA0 = 1'b0;
	end

endmodule

`default_nettype wire

// File: testbench/tb_user_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_user_io;

	import user_io_pkg::*;

	localparam int SCK_HALF = 4;
	localparam int FRAME_GAP = 12;
	localparam int PS2DIV = 4;
	localparam logic [7:0] CORE_TYPE = 8'ha4;
	// 13 user-io frames with 49 bytes, 8 download frames with 22 bytes
	localparam int FRAME_COUNT = 21;
	localparam int BYTE_COUNT = 71;
	localparam int FRAME_CYCLES = BYTE_COUNT * 16 * SCK_HALF
		+ FRAME_COUNT * (SCK_HALF + FRAME_GAP);
	localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 12 * 11 * 2 * PS2DIV;

	logic        clk_sys;
	logic        CONF_DATA0;
	logic        spi_sck;
	logic        spi_ss_io;
	logic        spi_ss_dl;
	logic        spi_di;
	logic        spi_do;
	logic [31:0] conf_str;
	logic        sd_conf;
	logic        sd_sdhc;
	logic        sd_rd;
	logic        sd_wr;
	logic [31:0] sd_lba;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	joy_analog_t joystick_analog_0;
	joy_analog_t joystick_analog_1;
	logic [1:0]  buttons;
	logic [1:0]  switches;
	logic        scandoubler_disable;
	logic        ypbpr;
	logic [31:0] status;
	logic [31:0] img_size;
	logic        img_mounted;
	logic        ps2_kbd_clk;
	logic        ps2_kbd_data;
	logic        ps2_mouse_clk;
	logic        ps2_mouse_data;
	ioctl_wr_t   ioctl;
	logic        ioctl_wr;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;

	int          seed;
	int          cycle_cnt = 0;
	int          mount_cnt = 0;
	logic [7:0]  tx_buf [16];
	logic [7:0]  rx_buf [16];
	logic [24:0] wr_addr_seen [$];
	logic [7:0]  wr_data_seen [$];
	logic [10:0] kbd_frame;
	logic [10:0] mouse_frame;
	int          kbd_bits = 0;
	int          mouse_bits = 0;
	logic [7:0]  kbd_seen [$];
	logic [7:0]  mouse_seen [$];

	tb_clk_gen #(
		.HALF_PERIOD  (4),
		.RESET_CYCLES (8)
	) i_clk_gen (
		.clk_sys    (clk_sys),
		.CONF_DATA0 (CONF_DATA0)
	);

	user_io_top #(
		.STRLEN (4),
		.PS2DIV (PS2DIV)
	) i_user_io_top (.*);

	task automatic report_failure(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else report_failure($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	// frame layout, LSB-first shift leaves the start bit in [0]
	task automatic check_ps2_frame(input string dev, input logic [10:0] f);
		assert (f[0] == 1'b0)
		else report_failure($sformatf("%s start bit is 1", dev));
		assert (^f[9:1] == 1'b1)
		else report_failure($sformatf("%s parity is not odd for %h", dev, f[8:1]));
		assert (f[10] == 1'b1)
		else report_failure($sformatf("%s stop bit is 0", dev));
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	// one frame on either select, full duplex, answer lands in rx_buf
	task automatic spi_frame(input bit to_dl, input int len);
		logic [7:0] got;
		if (to_dl) begin
			spi_ss_dl = 1'b0;
		end else begin
			spi_ss_io = 1'b0;
		end
		for (int i = 0; i < len; i++) begin
			for (int b = 7; b >= 0; b--) begin
				spi_di = tx_buf[i][b];
				wait_cycles(SCK_HALF);
				// slave output has settled by the end of the low half
				got[b] = spi_do;
				spi_sck = 1'b1;
				wait_cycles(SCK_HALF);
				spi_sck = 1'b0;
			end
			rx_buf[i] = got;
		end
		wait_cycles(SCK_HALF);
		spi_ss_io = 1'b1;
		spi_ss_dl = 1'b1;
		wait_cycles(FRAME_GAP);
		if (!to_dl) begin
			check_value("core type byte", rx_buf[0], CORE_TYPE);
		end
	endtask

	// opcode, then nargs bytes of args lowest first, then random filler
	task automatic send_frame(input bit to_dl, input logic [7:0] op, input logic [31:0] args,
		input int nargs, input int len);
		logic [31:0] r;
		tx_buf[0] = op;
		for (int i = 1; i < len; i++) begin
			r = $random(seed);
			tx_buf[i] = (i <= nargs) ? args[8*(i-1) +: 8] : r[7:0];
		end
		spi_frame(to_dl, len);
	endtask

	task automatic user_cmd(input logic [7:0] op, input logic [31:0] args, input int nargs);
		send_frame(1'b0, op, args, nargs, nargs + 1);
	endtask

	task automatic dl_cmd(input logic [7:0] op, input logic [31:0] args, input int nargs);
		send_frame(1'b1, op, args, nargs, nargs + 1);
	endtask

	task automatic check_reset_state();
		check_value("spi_do", spi_do, 0);
		check_value("ioctl_wr", ioctl_wr, 0);
		check_value("ioctl_download", ioctl_download, 0);
		check_value("img_mounted", img_mounted, 0);
		check_value("joystick_0", joystick_0, 0);
		check_value("joystick_1", joystick_1, 0);
		check_value("joystick_analog_0", joystick_analog_0, 0);
		check_value("joystick_analog_1", joystick_analog_1, 0);
		check_value("buttons", buttons, 0);
		check_value("switches", switches, 0);
		check_value("scandoubler_disable", scandoubler_disable, 0);
		check_value("ypbpr", ypbpr, 0);
		check_value("status", status, 0);
		check_value("img_size", img_size, 0);
		check_value("ioctl_index", ioctl_index, 0);
		check_value("ps2 pins", {ps2_kbd_clk, ps2_kbd_data, ps2_mouse_clk, ps2_mouse_data}, 4'hf);
	endtask

	task automatic check_responses();
		logic [31:0] r;
		// config string first byte first, zeros past its end
		send_frame(1'b0, GET_CONF_STR, 0, 0, 7);
		for (int n = 0; n < 4; n++) begin
			check_value("config string byte", rx_buf[1+n], conf_str[8*(3-n) +: 8]);
		end
		check_value("byte past config string", rx_buf[5], 0);
		check_value("byte past config string", rx_buf[6], 0);
		r = $random(seed);
		sd_conf = r[0];
		sd_sdhc = r[1];
		sd_rd = r[2];
		sd_wr = r[3];
		sd_lba = $random(seed);
		send_frame(1'b0, GET_SD_STAT, 0, 0, 6);
		check_value("sd status byte", rx_buf[1], {4'h5, r[0], r[1], r[3], r[2]});
		for (int n = 0; n < 4; n++) begin
			check_value("sd_lba byte", rx_buf[2+n], sd_lba[8*(3-n) +: 8]);
		end
	endtask

	task automatic check_registers();
		logic [31:0] r;
		logic [31:0] w;
		int          mounts;
		r = $random(seed);
		user_cmd(BUT_SW, r, 1);
		check_value("buttons", buttons, r[1:0]);
		check_value("switches", switches, r[3:2]);
		check_value("scandoubler_disable", scandoubler_disable, r[4]);
		check_value("ypbpr", ypbpr, r[5]);
		r = $random(seed);
		user_cmd(JOY0, r, 1);
		check_value("joystick_0", joystick_0, r[7:0]);
		r = $random(seed);
		user_cmd(JOY1, r, 1);
		check_value("joystick_1", joystick_1, r[7:0]);
		// 32 bit words go lowest byte first
		r = $random(seed);
		user_cmd(STATUS32, r, 4);
		check_value("status", status, r);
		w = $random(seed);
		user_cmd(STATUS8, w, 1);
		check_value("status after STATUS8", status, {r[31:8], w[7:0]});
		r = $random(seed);
		user_cmd(IMG_SIZE, r, 4);
		check_value("img_size", img_size, r);
		// stick, x, y
		r = $random(seed);
		user_cmd(JOY_ANALOG, {8'h00, r[15:8], r[7:0], 8'h00}, 3);
		check_value("joystick_analog_0", joystick_analog_0, {r[7:0], r[15:8]});
		check_value("joystick_analog_1", joystick_analog_1, 0);
		w = $random(seed);
		user_cmd(JOY_ANALOG, {8'h00, w[15:8], w[7:0], 8'h01}, 3);
		check_value("joystick_analog_1", joystick_analog_1, {w[7:0], w[15:8]});
		check_value("joystick_analog_0 kept", joystick_analog_0, {r[7:0], r[15:8]});
		mounts = mount_cnt;
		user_cmd(IMG_MOUNTED, 32'h1, 1);
		check_value("img_mounted pulses", mount_cnt, mounts + 1);
	endtask

	task automatic check_ps2();
		logic [31:0] keys;
		logic [31:0] moves;
		keys = $random(seed);
		moves = $random(seed);
		user_cmd(PS2_KBD, keys, 3);
		user_cmd(PS2_MOUSE, moves, 3);
		// bounded by the cycle counter
		while ((kbd_seen.size() < 3) || (mouse_seen.size() < 3)) begin
			@(posedge clk_sys);
		end
		wait_cycles(1);
		for (int n = 0; n < 3; n++) begin
			check_value("keyboard byte", kbd_seen[n], keys[8*n +: 8]);
			check_value("mouse byte", mouse_seen[n], moves[8*n +: 8]);
		end
	endtask

	task automatic check_download(input logic [7:0] index, input logic [24:0] base);
		logic [31:0] payload;
		wr_addr_seen.delete();
		wr_data_seen.delete();
		dl_cmd(FILE_INDEX, {24'h0, index}, 1);
		check_value("ioctl_index", ioctl_index, index);
		dl_cmd(FILE_TX, 32'h1, 1);
		check_value("ioctl_download after start", ioctl_download, 1);
		payload = $random(seed);
		dl_cmd(FILE_TX_DAT, payload, 4);
		dl_cmd(FILE_TX, 32'h0, 1);
		check_value("ioctl_download after end", ioctl_download, 0);
		check_value("ioctl write count", wr_addr_seen.size(), 4);
		for (int n = 0; n < 4; n++) begin
			check_value("ioctl address", wr_addr_seen[n], base + 25'(n));
			check_value("ioctl data", wr_data_seen[n], payload[8*n +: 8]);
		end
	endtask

	// PS/2 devices sample data on the falling clock edge
	always @(negedge ps2_kbd_clk) begin
		if (!CONF_DATA0) begin
			kbd_frame = {ps2_kbd_data, kbd_frame[10:1]};
			kbd_bits++;
			if (kbd_bits == 11) begin
				check_ps2_frame("keyboard", kbd_frame);
				kbd_seen.push_back(kbd_frame[8:1]);
				kbd_bits = 0;
			end
		end
	end

	always @(negedge ps2_mouse_clk) begin
		if (!CONF_DATA0) begin
			mouse_frame = {ps2_mouse_data, mouse_frame[10:1]};
			mouse_bits++;
			if (mouse_bits == 11) begin
				check_ps2_frame("mouse", mouse_frame);
				mouse_seen.push_back(mouse_frame[8:1]);
				mouse_bits = 0;
			end
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk_sys) begin
		if (!CONF_DATA0 && ioctl_wr) begin
			wr_addr_seen.push_back(ioctl.addr);
			wr_data_seen.push_back(ioctl.data);
		end
		if (!CONF_DATA0 && img_mounted) begin
			mount_cnt++;
		end
		if (i_user_io_top.i_user_io_props.fail_seen) begin
			report_failure("a bound property of the DUT failed");
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			report_failure($sformatf("timeout, run not done after %0d cycles", TIMEOUT_CYCLES));
		end
	end

	initial begin
		seed = 24429;
		spi_sck = 1'b0;
		spi_ss_io = 1'b1;
		spi_ss_dl = 1'b1;
		spi_di = 1'b0;
		conf_str = 32'h4d535831;
		sd_conf = 1'b0;
		sd_sdhc = 1'b0;
		sd_rd = 1'b0;
		sd_wr = 1'b0;
		sd_lba = '0;
		@(negedge CONF_DATA0);
		wait_cycles(2);
		check_reset_state();
		check_responses();
		check_registers();
		check_ps2();
		check_download(8'h01, 25'h0000100);
		check_download(8'h33, 25'h0100000);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/user_io_props.sv
`timescale 1ns/1ps
`default_nettype none

module user_io_props (
	input  logic clk_sys,
	input  logic CONF_DATA0,
	input  logic img_mounted,
	input  logic ioctl_wr,
	input  logic ioctl_download,
	input  logic ps2_clk_level,
	input  logic ps2_kbd_clk,
	input  logic ps2_kbd_data,
	input  logic ps2_mouse_clk,
	input  logic ps2_mouse_data,
	input  logic spi_ss_io,
	input  logic spi_do
);

	logic mount_bad = 1'b0;
	logic wr_bad = 1'b0;
	logic kbd_bad = 1'b0;
	logic mouse_bad = 1'b0;
	logic spi_bad = 1'b0;
	logic fail_seen;

	// set once any property has failed
	assign fail_seen = mount_bad | wr_bad | kbd_bad | mouse_bad | spi_bad;

	// mount notice lasts one cycle
	mount_pulse: assert property (@(posedge clk_sys) disable iff (CONF_DATA0)
		img_mounted |=> !img_mounted)
	else begin
		$error("img_mounted stayed high for two cycles");
		mount_bad <= 1'b1;
	end

	// no memory write outside a download
	wr_in_download: assert property (@(posedge clk_sys) disable iff (CONF_DATA0)
		ioctl_wr |-> ioctl_download)
	else begin
		$error("ioctl_wr raised while ioctl_download is low");
		wr_bad <= 1'b1;
	end

	// clock high while the divided clock is low means the channel is idle
	kbd_idle_high: assert property (@(posedge clk_sys) disable iff (CONF_DATA0)
		(ps2_kbd_clk && !ps2_clk_level) |-> ps2_kbd_data)
	else begin
		$error("keyboard data low while its channel is idle");
		kbd_bad <= 1'b1;
	end

	mouse_idle_high: assert property (@(posedge clk_sys) disable iff (CONF_DATA0)
		(ps2_mouse_clk && !ps2_clk_level) |-> ps2_mouse_data)
	else begin
		$error("mouse data low while its channel is idle");
		mouse_bad <= 1'b1;
	end

	spi_do_known: assert property (@(posedge clk_sys) disable iff (CONF_DATA0)
		!spi_ss_io |-> !$isunknown(spi_do))
	else begin
		$error("spi_do unknown during a user-io frame");
		spi_bad <= 1'b1;
	end

endmodule

bind user_io_top user_io_props i_user_io_props (
	.clk_sys        (clk_sys),
	.CONF_DATA0     (CONF_DATA0),
	.img_mounted    (img_mounted),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download),
	.ps2_clk_level  (ps2_clk_level),
	.ps2_kbd_clk    (ps2_kbd_clk),
	.ps2_kbd_data   (ps2_kbd_data),
	.ps2_mouse_clk  (ps2_mouse_clk),
	.ps2_mouse_data (ps2_mouse_data),
	.spi_ss_io      (spi_ss_io),
	.spi_do         (spi_do)
);

`default_nettype wire

// File: verilog/ioctl_download.sv
`timescale 1ns/1ps
`default_nettype none
`include "user_io_consts.svh"

module ioctl_download (
	input  logic                   clk_sys,
	input  logic                   CONF_DATA0,
	input  user_io_pkg::spi_byte_t rx,
	input  logic                   rx_valid,
	output user_io_pkg::ioctl_wr_t ioctl,
	output logic                   ioctl_wr,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index
);

	import user_io_pkg::*;

	dl_cmd_e     cmd;
	logic [24:0] addr;
	logic        arg_byte;

	// start address per menu index
	function automatic logic [24:0] dl_base(input logic [7:0] index);
		case (index)
			8'h00: dl_base = `UIO_DL_BASE_BOOT;
			8'h01, 8'h41: dl_base = `UIO_DL_BASE_ROM;
			8'h81: dl_base = `UIO_DL_BASE_C00;
			8'hc1: dl_base = `UIO_DL_BASE_EDD;
			default: dl_base = `UIO_DL_BASE_FDD;
		endcase
	endfunction

	assign arg_byte = rx_valid && (rx.index != 8'd0);

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			cmd <= dl_cmd_e'(8'h00);
			ioctl_wr <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (rx_valid && (rx.index == 8'd0)) begin
				cmd <= dl_cmd_e'(rx.data);
			end
			if (arg_byte) begin
				case (cmd)
					// bit 0 opens or closes the download
					FILE_TX: ioctl_download <= rx.data[0];
					// writes outside a download are ignored
					FILE_TX_DAT: ioctl_wr <= ioctl_download;
					FILE_INDEX: ioctl_index <= rx.data;
					default: ;
				endcase
			end
		end
	end

	// write address and data
	always_ff @(posedge clk_sys) begin
		if (arg_byte) begin
			if ((cmd == FILE_TX) && rx.data[0]) begin
				addr <= dl_base(ioctl_index);
			end else if ((cmd == FILE_TX_DAT) && ioctl_download) begin
				ioctl.addr <= addr;
				ioctl.data <= rx.data;
				addr <= addr + 25'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/ps2_tx_channel.sv
`timescale 1ns/1ps
`default_nettype none
`include "user_io_consts.svh"

module ps2_tx_channel (
	input  logic       clk_sys,
	input  logic       CONF_DATA0,
	input  logic [7:0] push_data,
	input  logic       push_valid,
	input  logic       ps2_tick,
	input  logic       ps2_clk_level,
	output logic       push_ready,
	output logic       ps2_clk,
	output logic       ps2_data
);

	import user_io_pkg::*;

	localparam int DEPTH = 1 << `UIO_PS2_FIFO_BITS;

	logic [7:0]                    fifo [DEPTH];
	// one extra pointer bit tells full from empty
	logic [`UIO_PS2_FIFO_BITS:0]   wptr;
	logic [`UIO_PS2_FIFO_BITS:0]   rptr;
	logic [`UIO_PS2_FIFO_BITS:0]   fill;
	logic [`UIO_PS2_FIFO_BITS-1:0] rd_addr;
	logic                          fifo_empty;
	logic                          push;
	ps2_state_e                    state;
	logic [7:0]                    tx_sr;
	logic [2:0]                    bit_cnt;
	logic                          parity;

	assign fill = wptr - rptr;
	assign rd_addr = rptr[`UIO_PS2_FIFO_BITS-1:0];
	assign fifo_empty = (wptr == rptr);
	// full when fill reaches DEPTH
	assign push_ready = ~fill[`UIO_PS2_FIFO_BITS];
	assign push = push_valid & push_ready;
	// clock only runs during a frame
	assign ps2_clk = (state == IDLE) ? 1'b1 : ps2_clk_level;

	always_ff @(posedge clk_sys) begin
		if (push) begin
			fifo[wptr[`UIO_PS2_FIFO_BITS-1:0]] <= push_data;
		end
		if (ps2_tick) begin
			if (state == IDLE) begin
				tx_sr <= fifo[rd_addr];
				// odd parity over the 8 data bits
				parity <= ~^fifo[rd_addr];
			end else if ((state == START) || (state == DATA)) begin
				tx_sr <= {1'b0, tx_sr[7:1]};
			end
		end
	end

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			wptr <= '0;
			rptr <= '0;
			state <= IDLE;
			bit_cnt <= '0;
			ps2_data <= 1'b1;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			// every bit changes on a tick
			if (ps2_tick) begin
				case (state)
					IDLE: begin
						if (!fifo_empty) begin
							ps2_data <= 1'b0;
							rptr <= rptr + 1'b1;
							state <= START;
						end
					end
					START: begin
						// bit 0 first
						ps2_data <= tx_sr[0];
						bit_cnt <= '0;
						state <= DATA;
					end
					DATA: begin
						if (bit_cnt == 3'd7) begin
							ps2_data <= parity;
							state <= PARITY;
						end else begin
							ps2_data <= tx_sr[0];
							bit_cnt <= bit_cnt + 3'd1;
						end
					end
					PARITY: begin
						// stop bit, line stays high after
						ps2_data <= 1'b1;
						state <= STOP;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/spi_byte_link.sv
`timescale 1ns/1ps
`default_nettype none
`include "user_io_consts.svh"

module spi_byte_link (
	input  logic                   clk_sys,
	input  logic                   CONF_DATA0,
	input  logic                   spi_sck,
	input  logic                   spi_ss,
	input  logic                   spi_di,
	input  logic [7:0]             tx_byte,
	output logic                   spi_do,
	output user_io_pkg::spi_byte_t rx,
	output logic                   rx_valid
);

	logic [`UIO_SYNC_STAGES-1:0] sck_sync;
	logic [`UIO_SYNC_STAGES-1:0] ss_sync;
	logic [`UIO_SYNC_STAGES-1:0] di_sync;
	logic                        sck_d;
	logic                        ss_d;
	logic                        sck_s;
	logic                        ss_s;
	logic                        di_s;
	logic                        sck_rise;
	logic                        sck_fall;
	logic                        ss_fall;
	logic                        tx_load;
	logic [2:0]                  bit_cnt;
	logic [7:0]                  byte_cnt;
	logic [6:0]                  rx_sr;
	logic [6:0]                  tx_sr;

	assign sck_s = sck_sync[`UIO_SYNC_STAGES-1];
	assign ss_s = ss_sync[`UIO_SYNC_STAGES-1];
	assign di_s = di_sync[`UIO_SYNC_STAGES-1];
	// edges seen two cycles late, acted on in the third
	assign sck_rise = sck_s & ~sck_d;
	assign sck_fall = ~sck_s & sck_d;
	assign ss_fall = ~ss_s & ss_d;
	// next byte goes out at frame start or after the 8th bit
	assign tx_load = ss_fall | (sck_fall & (bit_cnt == 3'd0));

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			sck_sync <= '0;
			ss_sync <= '1;
			di_sync <= '0;
			sck_d <= 1'b0;
			ss_d <= 1'b1;
		end else begin
			sck_sync <= {sck_sync[`UIO_SYNC_STAGES-2:0], spi_sck};
			ss_sync <= {ss_sync[`UIO_SYNC_STAGES-2:0], spi_ss};
			di_sync <= {di_sync[`UIO_SYNC_STAGES-2:0], spi_di};
			sck_d <= sck_s;
			ss_d <= ss_s;
		end
	end

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			bit_cnt <= '0;
			byte_cnt <= '0;
			rx_valid <= 1'b0;
			rx <= '{data: 8'h00, index: 8'hff};
			spi_do <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (ss_s) begin
				// between frames, index ff so the next one reads as 0
				bit_cnt <= '0;
				byte_cnt <= '0;
				rx.index <= 8'hff;
				spi_do <= 1'b0;
			end else begin
				if (sck_rise) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						rx.data <= {rx_sr, di_s};
						rx.index <= byte_cnt;
						rx_valid <= 1'b1;
						if (byte_cnt != 8'hff) begin
							byte_cnt <= byte_cnt + 8'd1;
						end
					end
				end
				// msb first on falling edges
				if (tx_load) begin
					spi_do <= tx_byte[7];
				end else if (sck_fall) begin
					spi_do <= tx_sr[6];
				end
			end
		end
	end

	// shift registers
	always_ff @(posedge clk_sys) begin
		if (sck_rise) begin
			rx_sr <= {rx_sr[5:0], di_s};
		end
		if (tx_load) begin
			tx_sr <= tx_byte[6:0];
		end else if (sck_fall) begin
			tx_sr <= {tx_sr[5:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: verilog/uio_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "user_io_consts.svh"

module uio_cmd_decoder #(
	parameter int STRLEN = 1
) (
	input  logic                     clk_sys,
	input  logic                     CONF_DATA0,
	input  user_io_pkg::spi_byte_t   rx,
	input  logic                     rx_valid,
	input  logic [8*STRLEN-1:0]      conf_str,
	input  logic                     sd_conf,
	input  logic                     sd_sdhc,
	input  logic                     sd_rd,
	input  logic                     sd_wr,
	input  logic [31:0]              sd_lba,
	output logic [7:0]               tx_byte,
	output logic [7:0]               joystick_0,
	output logic [7:0]               joystick_1,
	output user_io_pkg::joy_analog_t joystick_analog_0,
	output user_io_pkg::joy_analog_t joystick_analog_1,
	output logic [1:0]               buttons,
	output logic [1:0]               switches,
	output logic                     scandoubler_disable,
	output logic                     ypbpr,
	output logic [31:0]              status,
	output logic [31:0]              img_size,
	output logic                     img_mounted,
	output logic [7:0]               kbd_push_data,
	output logic [7:0]               mouse_push_data,
	output logic                     kbd_push_valid,
	output logic                     mouse_push_valid,
	input  logic                     kbd_push_ready,
	input  logic                     mouse_push_ready
);

	import user_io_pkg::*;

	uio_cmd_e   cmd;
	logic [5:0] but_sw;
	logic [2:0] stick_idx;
	logic       arg_byte;
	logic [1:0] byte_sel;
	logic [7:0] next_idx;
	logic [7:0] sd_stat;

	// any byte after the opcode
	assign arg_byte = rx_valid && (rx.index != 8'd0);
	// little endian lane for bytes 1 to 4
	assign byte_sel = rx.index[1:0] - 2'd1;
	// wraps ff to 0 at frame start
	assign next_idx = rx.index + 8'd1;
	assign sd_stat = {4'h5, sd_conf, sd_sdhc, sd_wr, sd_rd};

	assign buttons = but_sw[1:0];
	assign switches = but_sw[3:2];
	assign scandoubler_disable = but_sw[4];
	assign ypbpr = but_sw[5];

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			cmd <= uio_cmd_e'(8'h00);
			but_sw <= '0;
			stick_idx <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			joystick_analog_0 <= '0;
			joystick_analog_1 <= '0;
			status <= '0;
			img_size <= '0;
			img_mounted <= 1'b0;
			kbd_push_valid <= 1'b0;
			mouse_push_valid <= 1'b0;
		end else begin
			img_mounted <= 1'b0;
			// pending byte held until the queue takes it
			kbd_push_valid <= kbd_push_valid & ~kbd_push_ready;
			mouse_push_valid <= mouse_push_valid & ~mouse_push_ready;
			if (rx_valid && (rx.index == 8'd0)) begin
				cmd <= uio_cmd_e'(rx.data);
			end
			if (arg_byte) begin
				case (cmd)
					BUT_SW: but_sw <= rx.data[5:0];
					JOY0: joystick_0 <= rx.data;
					JOY1: joystick_1 <= rx.data;
					PS2_MOUSE: mouse_push_valid <= 1'b1;
					PS2_KBD: kbd_push_valid <= 1'b1;
					STATUS8: status[7:0] <= rx.data;
					IMG_MOUNTED: img_mounted <= 1'b1;
					JOY_ANALOG: begin
						// stick, then x, then y
						if (rx.index == 8'd1) begin
							stick_idx <= rx.data[2:0];
						end else if (rx.index == 8'd2) begin
							if (stick_idx == 3'd0) begin
								joystick_analog_0.x <= rx.data;
							end else if (stick_idx == 3'd1) begin
								joystick_analog_1.x <= rx.data;
							end
						end else if (rx.index == 8'd3) begin
							if (stick_idx == 3'd0) begin
								joystick_analog_0.y <= rx.data;
							end else if (stick_idx == 3'd1) begin
								joystick_analog_1.y <= rx.data;
							end
						end
					end
					IMG_SIZE: begin
						if (rx.index < 8'd5) begin
							img_size[{byte_sel, 3'b000} +: 8] <= rx.data;
						end
					end
					STATUS32: begin
						if (rx.index < 8'd5) begin
							status[{byte_sel, 3'b000} +: 8] <= rx.data;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// a new byte replaces one still pending, the old one is lost
	always_ff @(posedge clk_sys) begin
		if (arg_byte && (cmd == PS2_KBD)) begin
			kbd_push_data <= rx.data;
		end
		if (arg_byte && (cmd == PS2_MOUSE)) begin
			mouse_push_data <= rx.data;
		end
	end

	// answer byte for the next slot of the frame
	always_comb begin
		tx_byte = 8'h00;
		if (next_idx == 8'd0) begin
			tx_byte = `UIO_CORE_TYPE;
		end else if (cmd == GET_CONF_STR) begin
			// string bytes from the top of conf_str down
			if (int'(next_idx) <= STRLEN) begin
				tx_byte = conf_str[8*(STRLEN - int'(next_idx)) +: 8];
			end
		end else if (cmd == GET_SD_STAT) begin
			if (next_idx == 8'd1) begin
				tx_byte = sd_stat;
			end else if (next_idx <= 8'd5) begin
				tx_byte = sd_lba[8*(5 - int'(next_idx)) +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/user_io_pkg.sv
`default_nettype none

package user_io_pkg;

	// user-io opcodes, byte 0 of a frame
	typedef enum logic [7:0] {
		BUT_SW       = 8'h01,
		JOY0         = 8'h02,
		JOY1         = 8'h03,
		PS2_MOUSE    = 8'h04,
		PS2_KBD      = 8'h05,
		GET_CONF_STR = 8'h14,
		STATUS8      = 8'h15,
		GET_SD_STAT  = 8'h16,
		JOY_ANALOG   = 8'h1a,
		IMG_MOUNTED  = 8'h1c,
		IMG_SIZE     = 8'h1d,
		STATUS32     = 8'h1e
	} uio_cmd_e;

	// download channel opcodes
	typedef enum logic [7:0] {
		FILE_TX     = 8'h53,
		FILE_TX_DAT = 8'h54,
		FILE_INDEX  = 8'h55
	} dl_cmd_e;

	// ps2 serializer, state names what is on the data line
	typedef enum logic [3:0] {
		IDLE,
		START,
		DATA,
		PARITY,
		STOP
	} ps2_state_e;

	// one spi byte, index saturates at 255
	typedef struct packed {
		logic [7:0] data;
		logic [7:0] index;
	} spi_byte_t;

	typedef struct packed {
		logic [24:0] addr;
		logic [7:0]  data;
	} ioctl_wr_t;

	// x in the upper byte
	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
	} joy_analog_t;

endpackage

`default_nettype wire

// File: verilog/user_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module user_io_top #(
	parameter int STRLEN = 1,
	parameter int PS2DIV = 100
) (
	input  logic                     clk_sys,
	input  logic                     CONF_DATA0,
	input  logic                     spi_sck,
	input  logic                     spi_ss_io,
	input  logic                     spi_ss_dl,
	input  logic                     spi_di,
	output logic                     spi_do,
	input  logic [8*STRLEN-1:0]      conf_str,
	input  logic                     sd_conf,
	input  logic                     sd_sdhc,
	input  logic                     sd_rd,
	input  logic                     sd_wr,
	input  logic [31:0]              sd_lba,
	output logic [7:0]               joystick_0,
	output logic [7:0]               joystick_1,
	output user_io_pkg::joy_analog_t joystick_analog_0,
	output user_io_pkg::joy_analog_t joystick_analog_1,
	output logic [1:0]               buttons,
	output logic [1:0]               switches,
	output logic                     scandoubler_disable,
	output logic                     ypbpr,
	output logic [31:0]              status,
	output logic [31:0]              img_size,
	output logic                     img_mounted,
	output logic                     ps2_kbd_clk,
	output logic                     ps2_kbd_data,
	output logic                     ps2_mouse_clk,
	output logic                     ps2_mouse_data,
	output user_io_pkg::ioctl_wr_t   ioctl,
	output logic                     ioctl_wr,
	output logic                     ioctl_download,
	output logic [7:0]               ioctl_index
);

	import user_io_pkg::*;

	localparam int DIV_W = $clog2(PS2DIV + 1);

	spi_byte_t        io_rx;
	spi_byte_t        dl_rx;
	logic             io_rx_valid;
	logic             dl_rx_valid;
	logic [7:0]       io_tx_byte;
	logic [7:0]       kbd_push_data;
	logic [7:0]       mouse_push_data;
	logic             kbd_push_valid;
	logic             mouse_push_valid;
	logic             kbd_push_ready;
	logic             mouse_push_ready;
	logic [DIV_W-1:0] div_cnt;
	logic             ps2_tick;
	logic             ps2_clk_level;

	// ps2 clock is clk_sys / (2*PS2DIV)
	// tick marks each rising edge of the divided clock
	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			div_cnt <= '0;
			ps2_tick <= 1'b0;
			ps2_clk_level <= 1'b0;
		end else begin
			ps2_tick <= 1'b0;
			if (div_cnt == DIV_W'(PS2DIV - 1)) begin
				div_cnt <= '0;
				ps2_clk_level <= ~ps2_clk_level;
				ps2_tick <= ~ps2_clk_level;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	spi_byte_link i_io_link (
		.clk_sys    (clk_sys),
		.CONF_DATA0 (CONF_DATA0),
		.spi_sck    (spi_sck),
		.spi_ss     (spi_ss_io),
		.spi_di     (spi_di),
		.tx_byte    (io_tx_byte),
		.spi_do     (spi_do),
		.rx         (io_rx),
		.rx_valid   (io_rx_valid)
	);

	// download channel only listens
	spi_byte_link i_dl_link (
		.clk_sys    (clk_sys),
		.CONF_DATA0 (CONF_DATA0),
		.spi_sck    (spi_sck),
		.spi_ss     (spi_ss_dl),
		.spi_di     (spi_di),
		.tx_byte    (8'h00),
		.spi_do     (),
		.rx         (dl_rx),
		.rx_valid   (dl_rx_valid)
	);

	uio_cmd_decoder #(
		.STRLEN (STRLEN)
	) i_decoder (
		.clk_sys             (clk_sys),
		.CONF_DATA0          (CONF_DATA0),
		.rx                  (io_rx),
		.rx_valid            (io_rx_valid),
		.conf_str            (conf_str),
		.sd_conf             (sd_conf),
		.sd_sdhc             (sd_sdhc),
		.sd_rd               (sd_rd),
		.sd_wr               (sd_wr),
		.sd_lba              (sd_lba),
		.tx_byte             (io_tx_byte),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.joystick_analog_0   (joystick_analog_0),
		.joystick_analog_1   (joystick_analog_1),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.ypbpr               (ypbpr),
		.status              (status),
		.img_size            (img_size),
		.img_mounted         (img_mounted),
		.kbd_push_data       (kbd_push_data),
		.mouse_push_data     (mouse_push_data),
		.kbd_push_valid      (kbd_push_valid),
		.mouse_push_valid    (mouse_push_valid),
		.kbd_push_ready      (kbd_push_ready),
		.mouse_push_ready    (mouse_push_ready)
	);

	ps2_tx_channel i_ps2_kbd (
		.clk_sys       (clk_sys),
		.CONF_DATA0    (CONF_DATA0),
		.push_data     (kbd_push_data),
		.push_valid    (kbd_push_valid),
		.ps2_tick      (ps2_tick),
		.ps2_clk_level (ps2_clk_level),
		.push_ready    (kbd_push_ready),
		.ps2_clk       (ps2_kbd_clk),
		.ps2_data      (ps2_kbd_data)
	);

	ps2_tx_channel i_ps2_mouse (
		.clk_sys       (clk_sys),
		.CONF_DATA0    (CONF_DATA0),
		.push_data     (mouse_push_data),
		.push_valid    (mouse_push_valid),
		.ps2_tick      (ps2_tick),
		.ps2_clk_level (ps2_clk_level),
		.push_ready    (mouse_push_ready),
		.ps2_clk       (ps2_mouse_clk),
		.ps2_data      (ps2_mouse_data)
	);

	ioctl_download i_download (
		.clk_sys        (clk_sys),
		.CONF_DATA0     (CONF_DATA0),
		.rx             (dl_rx),
		.rx_valid       (dl_rx_valid),
		.ioctl          (ioctl),
		.ioctl_wr       (ioctl_wr),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index)
	);

endmodule

`default_nettype wire
